// File: src/simil_pkg.sv
`default_nettype none

package simil_pkg;

    localparam int LANES  = 2;
    localparam int STEP_W = 16;

    typedef logic [15:0] fp16_t;
    typedef logic [2:0]  phase_t;

    ////////////////////
    // fp16 constants
    ////////////////////
    localparam int    FP16_BIAS  = 15;
    localparam fp16_t FP16_ONE   = 16'h3C00;
    localparam fp16_t FP16_MAX   = 16'h7BFF;
    localparam fp16_t SIM_THRESH = 16'h3BD7;

    // Position sentinel when no centre passes the threshold
    localparam logic [15:0] NO_CENTRE = 16'h1000;

    // Phase numbers
    localparam phase_t PH_TILE   = 3'd1;
    localparam phase_t PH_SQRT   = 3'd4;
    localparam phase_t PH_MAX    = 3'd5;
    localparam phase_t PH_SELECT = 3'd6;
    localparam phase_t PH_DONE   = 3'd7;

    // Boundaries must be non-decreasing from b0 to b6
    typedef struct packed {
        logic [STEP_W-1:0] b6;
        logic [STEP_W-1:0] b5;
        logic [STEP_W-1:0] b4;
        logic [STEP_W-1:0] b3;
        logic [STEP_W-1:0] b2;
        logic [STEP_W-1:0] b1;
        logic [STEP_W-1:0] b0;
    } phase_bounds_t;

    typedef struct packed {
        fp16_t       operand;
        fp16_t       scale;
        fp16_t       norm;
        logic [15:0] pos;
    } lane_in_t;

    typedef struct packed {
        fp16_t op1;
        fp16_t op2;
    } lane_out_t;

    typedef lane_in_t  [LANES-1:0] lane_in_vec_t;
    typedef lane_out_t [LANES-1:0] lane_out_vec_t;

    ////////////////////
    // Lookup tables
    ////////////////////
    typedef logic [127:0][9:0] recip_tab_t;
    typedef logic [255:0][9:0] sqrt_tab_t;

    // Mantissa of 2/m, sampled at the middle of each 1/128 interval
    function automatic recip_tab_t build_recip_tab();
        recip_tab_t  tab;
        int unsigned m;
        for (int i = 0; i < 128; i++) begin
            m      = 256 + 2 * i + 1;
            tab[i] = 10'((524288 / m) - 1024);
        end
        return tab;
    endfunction

    // Upper half of the table is for odd exponents, significand doubled
    function automatic sqrt_tab_t build_sqrt_tab();
        sqrt_tab_t   tab;
        int unsigned v;
        int unsigned r;
        int unsigned t;
        for (int i = 0; i < 256; i++) begin
            v = (256 + 2 * (i % 128) + 1) * 4096;
            if (i >= 128) begin
                v = v * 2;
            end
            r = 0;
            // Bitwise integer square root
            for (int b = 11; b >= 0; b--) begin
                t = r | (1 << b);
                if (t * t <= v) begin
                    r = t;
                end
            end
            tab[i] = 10'(r - 1024);
        end
        return tab;
    endfunction

    localparam recip_tab_t RECIP_TAB = build_recip_tab();
    localparam sqrt_tab_t  SQRT_TAB  = build_sqrt_tab();

endpackage

`default_nettype wire

// File: src/fp16_mul.sv
`timescale 1ns/1ns
`default_nettype none

module fp16_mul (
    input  simil_pkg::fp16_t a_i,
    input  simil_pkg::fp16_t b_i,
    output simil_pkg::fp16_t prod_o
);

    logic        sign;
    logic [4:0]  exp_a;
    logic [4:0]  exp_b;
    logic [21:0] sig_prod;
    logic [9:0]  man;
    int          exp_sum;

    always_comb begin
        sign  = a_i[15] ^ b_i[15];
        exp_a = a_i[14:10];
        exp_b = b_i[14:10];

        // 11 x 11 bit significands, product in [1, 4)
        sig_prod = {1'b1, a_i[9:0]} * {1'b1, b_i[9:0]};
        exp_sum  = int'(exp_a) + int'(exp_b) - simil_pkg::FP16_BIAS;

        // Normalise by one bit, truncate the rest
        if (sig_prod[21]) begin
            man     = sig_prod[20:11];
            exp_sum = exp_sum + 1;
        end else begin
            man = sig_prod[19:10];
        end

        // Zero or subnormal operands flush to zero
        if (exp_a == 5'd0 || exp_b == 5'd0 || exp_sum <= 0) begin
            prod_o = '0;
        end else if (exp_sum >= 31) begin
            prod_o = {sign, simil_pkg::FP16_MAX[14:0]};
        end else begin
            prod_o = {sign, exp_sum[4:0], man};
        end
    end

endmodule

`default_nettype wire

// File: src/fp16_recip_rom.sv
`timescale 1ns/1ns
`default_nettype none

module fp16_recip_rom (
    input  simil_pkg::fp16_t x_i,
    output simil_pkg::fp16_t recip_o
);

    logic [4:0] exp_in;
    logic [9:0] man_in;
    logic [9:0] man_out;
    int         exp_out;

    assign exp_in = x_i[14:10];
    assign man_in = x_i[9:0];

    always_comb begin
        // Exact power of two when the mantissa is zero
        if (man_in == 10'd0) begin
            man_out = '0;
            exp_out = 2 * simil_pkg::FP16_BIAS - int'(exp_in);
        end else begin
            man_out = simil_pkg::RECIP_TAB[man_in[9:3]];
            exp_out = 2 * simil_pkg::FP16_BIAS - int'(exp_in) - 1;
        end

        if (exp_in == 5'd0) begin
            recip_o = {x_i[15], simil_pkg::FP16_MAX[14:0]};
        end else if (exp_out <= 0) begin
            recip_o = '0;
        end else begin
            recip_o = {x_i[15], exp_out[4:0], man_out};
        end
    end

endmodule

`default_nettype wire

// File: src/fp16_sqrt_rom.sv
`timescale 1ns/1ns
`default_nettype none

module fp16_sqrt_rom (
    input  simil_pkg::fp16_t x_i,
    output simil_pkg::fp16_t root_o
);

    logic [4:0] exp_in;
    logic [7:0] tab_idx;
    int         exp_unb;
    int         exp_out;

    assign exp_in = x_i[14:10];

    always_comb begin
        exp_unb = int'(exp_in) - simil_pkg::FP16_BIAS;

        // Floor halving, odd exponents pick the upper table half
        exp_out = (exp_unb >>> 1) + simil_pkg::FP16_BIAS;
        tab_idx = {exp_unb[0], x_i[9:3]};

        if (x_i[15] || exp_in == 5'd0) begin
            root_o = '0;
        end else begin
            root_o = {1'b0, exp_out[4:0], simil_pkg::SQRT_TAB[tab_idx]};
        end
    end

endmodule

`default_nettype wire

// File: src/norm_lane.sv
`timescale 1ns/1ns
`default_nettype none

module norm_lane (
    input  logic                 CLK_i,
    input  logic                 RST_i,
    input  simil_pkg::phase_t    phase_i,
    input  simil_pkg::lane_in_t  in_i,
    output simil_pkg::lane_out_t out_o
);

    simil_pkg::fp16_t norm_prod;
    simil_pkg::fp16_t recip_in;
    simil_pkg::fp16_t recip;
    simil_pkg::fp16_t scaled;
    simil_pkg::fp16_t root;
    simil_pkg::fp16_t cmp_ref;
    simil_pkg::fp16_t max_q;
    logic [15:0]      pos_q;
    logic             gt;

    // Strict a > b on sign-magnitude fp16
    function automatic logic fp16_gt(simil_pkg::fp16_t a, simil_pkg::fp16_t b);
        if (a[15] != b[15]) begin
            return !a[15] && ((a[14:0] | b[14:0]) != 15'd0);
        end else if (!a[15]) begin
            return a[14:0] > b[14:0];
        end else begin
            return a[14:0] < b[14:0];
        end
    endfunction

    ////////////////////
    // Arithmetic
    ////////////////////
    fp16_mul norm_mul (.a_i(in_i.scale), .b_i(in_i.norm), .prod_o(norm_prod));

    assign recip_in = (phase_i == simil_pkg::PH_MAX) ? norm_prod : in_i.scale;

    fp16_recip_rom recip_rom (.x_i(recip_in), .recip_o(recip));
    fp16_mul scaled_mul (.a_i(in_i.operand), .b_i(recip), .prod_o(scaled));
    fp16_sqrt_rom sqrt_rom (.x_i(in_i.operand), .root_o(root));

    // Running maximum in phase 5, threshold otherwise
    assign cmp_ref = (phase_i == simil_pkg::PH_MAX) ? max_q : simil_pkg::SIM_THRESH;
    assign gt      = fp16_gt(scaled, cmp_ref);

    always_ff @(posedge CLK_i or posedge RST_i) begin
        if (RST_i) begin
            max_q <= '0;
            pos_q <= '0;
        end else if (phase_i == simil_pkg::PH_MAX && gt) begin
            max_q <= scaled;
            pos_q <= in_i.pos;
        end
    end

    ////////////////////
    // Output select
    ////////////////////
    always_comb begin
        out_o.op2 = simil_pkg::FP16_ONE;
        case (phase_i)
            simil_pkg::PH_SQRT,
            simil_pkg::PH_MAX: begin
                out_o.op1 = root;
            end
            simil_pkg::PH_SELECT: begin
                if (gt) begin
                    out_o.op1 = pos_q;
                    out_o.op2 = scaled;
                end else begin
                    out_o.op1 = simil_pkg::NO_CENTRE;
                end
            end
            default: begin
                out_o.op1 = scaled;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/phase_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module phase_sequencer (
    input  logic                     CLK_i,
    input  logic                     RST_i,
    input  logic                     stall_i,
    input  simil_pkg::phase_bounds_t bounds_i,
    output simil_pkg::phase_t        phase_o,
    output logic                     finished_o,
    output logic                     mode_o
);

    logic [simil_pkg::STEP_W-1:0] step_q;
    simil_pkg::phase_t            phase_q;
    simil_pkg::phase_t            phase_next;

    // Number of boundaries strictly below the current step
    always_comb begin
        phase_next = '0;
        if (bounds_i.b0 < step_q) phase_next = phase_next + 3'd1;
        if (bounds_i.b1 < step_q) phase_next = phase_next + 3'd1;
        if (bounds_i.b2 < step_q) phase_next = phase_next + 3'd1;
        if (bounds_i.b3 < step_q) phase_next = phase_next + 3'd1;
        if (bounds_i.b4 < step_q) phase_next = phase_next + 3'd1;
        if (bounds_i.b5 < step_q) phase_next = phase_next + 3'd1;
        if (bounds_i.b6 < step_q) phase_next = phase_next + 3'd1;
    end

    ////////////////////
    // Step and phase
    ////////////////////
    always_ff @(posedge CLK_i or posedge RST_i) begin
        if (RST_i) begin
            step_q  <= '0;
            phase_q <= '0;
        end else if (!stall_i) begin
            step_q  <= step_q + 1'b1;
            phase_q <= phase_next;
        end
    end

    assign phase_o    = phase_q;
    assign finished_o = (phase_q == simil_pkg::PH_DONE);

    // Tile runs in its alternate mode only during phase 1
    assign mode_o = (phase_q != simil_pkg::PH_TILE);

endmodule

`default_nettype wire

// File: src/simil_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module simil_stage_top (
    input  logic                     CLK_i,
    input  logic                     RST_i,
    input  logic                     stall_i,
    input  simil_pkg::phase_bounds_t bounds_i,
    input  simil_pkg::lane_in_vec_t  lanes_i,
    output simil_pkg::lane_out_vec_t lanes_o,
    output simil_pkg::phase_t        phase_o,
    output logic                     finished_o,
    output logic                     mode_o
);

    simil_pkg::phase_t phase;

    phase_sequencer phase_sequencer_inst (
        .CLK_i      (CLK_i),
        .RST_i      (RST_i),
        .stall_i    (stall_i),
        .bounds_i   (bounds_i),
        .phase_o    (phase),
        .finished_o (finished_o),
        .mode_o     (mode_o)
    );

    assign phase_o = phase;

    // One lane per vector element, all sharing the phase
    for (genvar i = 0; i < simil_pkg::LANES; i++) begin : g_lane
        norm_lane norm_lane_inst (
            .CLK_i   (CLK_i),
            .RST_i   (RST_i),
            .phase_i (phase),
            .in_i    (lanes_i[i]),
            .out_o   (lanes_o[i])
        );
    end

endmodule

`default_nettype wire

// File: bench/simil_stage_chk.sv
`timescale 1ns/1ns
`default_nettype none

module simil_stage_chk (
    input logic              CLK_i,
    input logic              RST_i,
    input logic              stall_i,
    input simil_pkg::phase_t phase_o,
    input logic              finished_o,
    input logic              mode_o
);

    // Assertion failures so far
    int fail_cnt = 0;

    // Phase only moves forward between resets
    phase_monotonic: assert property (
        @(posedge CLK_i) disable iff (RST_i) phase_o >= $past(phase_o)
    ) else begin
        fail_cnt++;
        $error("phase decreased from %0d to %0d", $past(phase_o), phase_o);
    end

    phase_hold_on_stall: assert property (
        @(posedge CLK_i) disable iff (RST_i) stall_i |=> $stable(phase_o)
    ) else begin
        fail_cnt++;
        $error("phase changed during a stall");
    end

    // Finished stays high until the next reset
    finished_sticky: assert property (
        @(posedge CLK_i) disable iff (RST_i) finished_o |=> finished_o
    ) else begin
        fail_cnt++;
        $error("finished_o dropped after going high");
    end

    // Tile mode is only entered on the step out of phase 0
    mode_entry: assert property (
        @(posedge CLK_i) disable iff (RST_i) $fell(mode_o) |-> $past(phase_o) == 3'd0
    ) else begin
        fail_cnt++;
        $error("mode_o fell after phase %0d", $past(phase_o));
    end

endmodule

bind phase_sequencer simil_stage_chk chk_inst (
    .CLK_i      (CLK_i),
    .RST_i      (RST_i),
    .stall_i    (stall_i),
    .phase_o    (phase_o),
    .finished_o (finished_o),
    .mode_o     (mode_o)
);

`default_nettype wire

// File: bench/simil_stage_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module simil_stage_monitor (
    input  logic                     CLK_i,
    input  logic                     RST_i,
    input  logic                     stall_i,
    input  logic                     check_i,
    input  int                       rec_i,
    input  simil_pkg::lane_out_vec_t lanes_i,
    input  simil_pkg::phase_t        phase_i,
    input  logic                     finished_i,
    input  logic                     mode_i,
    output int                       err_cnt_o,
    output int                       fail_tests_o
);

    localparam int NUM_REC = 9;
    localparam int REC_W   = 14;

    logic [15:0]       vec [0:7+NUM_REC*REC_W-1];
    logic [15:0]       step_m;
    simil_pkg::phase_t phase_m;
    int                rec_err;

    initial begin
        $readmemh("bench/simil_stage_input.txt", vec);
        err_cnt_o    = 0;
        fail_tests_o = 0;
        rec_err      = 0;
    end

    // Reference phase: boundaries strictly below the step count
    function automatic simil_pkg::phase_t bounds_below(logic [15:0] s);
        simil_pkg::phase_t n;
        n = '0;
        for (int i = 0; i < 7; i++) begin
            if (vec[i] < s) begin
                n = n + 3'd1;
            end
        end
        return n;
    endfunction

    always @(posedge CLK_i or posedge RST_i) begin
        if (RST_i) begin
            step_m  <= '0;
            phase_m <= '0;
        end else if (!stall_i) begin
            step_m  <= step_m + 16'd1;
            phase_m <= bounds_below(step_m);
        end
    end

    task automatic compare(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            err_cnt_o++;
            rec_err++;
        end
    endtask

    ////////////////////
    // Sampling at the falling edge
    ////////////////////
    always @(negedge CLK_i) begin
        int base;
        if (!RST_i) begin
            compare("phase_o", 16'(phase_i), 16'(phase_m));
            compare("finished_o", 16'(finished_i), 16'(phase_m == simil_pkg::PH_DONE));
            compare("mode_o", 16'(mode_i), 16'(phase_m != simil_pkg::PH_TILE));
            if (check_i) begin
                base = 7 + rec_i * REC_W;
                compare("lanes_o[0].op1", lanes_i[0].op1, vec[base+9]);
                compare("lanes_o[0].op2", lanes_i[0].op2, vec[base+10]);
                compare("lanes_o[1].op1", lanes_i[1].op1, vec[base+11]);
                compare("lanes_o[1].op2", lanes_i[1].op2, vec[base+12]);
                compare("phase_o (file)", 16'(phase_i), vec[base+13]);
                $display("test %0d phase %0d %s", rec_i, phase_i,
                         (rec_err == 0) ? "passed" : "failed");
                if (rec_err != 0) begin
                    fail_tests_o++;
                end
                rec_err = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/simil_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module simil_stage_tb;

    localparam int NUM_REC   = 9;
    localparam int REC_W     = 14;
    localparam int MAX_TRIES = 8;
    localparam int DONE_WAIT = 50;

    logic                     CLK_i;
    logic                     RST_i;
    logic                     stall;
    logic                     check;
    int                       rec;
    simil_pkg::phase_bounds_t bounds;
    simil_pkg::lane_in_vec_t  lanes_in;
    simil_pkg::lane_out_vec_t lanes_out;
    simil_pkg::phase_t        phase;
    logic                     finished;
    logic                     mode;
    int                       err_cnt;
    int                       fail_tests;
    logic [15:0]              vec [0:7+NUM_REC*REC_W-1];

    initial begin
        CLK_i = 1'b0;
        forever #20 CLK_i = ~CLK_i;
    end

    simil_stage_top simil_stage_top_inst (
        .CLK_i      (CLK_i),
        .RST_i      (RST_i),
        .stall_i    (stall),
        .bounds_i   (bounds),
        .lanes_i    (lanes_in),
        .lanes_o    (lanes_out),
        .phase_o    (phase),
        .finished_o (finished),
        .mode_o     (mode)
    );

    simil_stage_monitor monitor_inst (
        .CLK_i        (CLK_i),
        .RST_i        (RST_i),
        .stall_i      (stall),
        .check_i      (check),
        .rec_i        (rec),
        .lanes_i      (lanes_out),
        .phase_i      (phase),
        .finished_i   (finished),
        .mode_i       (mode),
        .err_cnt_o    (err_cnt),
        .fail_tests_o (fail_tests)
    );

    // One unstalled edge after a few random stall cycles
    task automatic free_step();
        for (int t = 0; t < MAX_TRIES; t++) begin
            @(posedge CLK_i);
            if (t < MAX_TRIES - 1 && $urandom_range(3, 0) == 0) begin
                stall <= 1'b1;
            end else begin
                stall <= 1'b0;
                break;
            end
        end
    endtask

    task automatic load_lanes(int base);
        for (int l = 0; l < simil_pkg::LANES; l++) begin
            lanes_in[l].operand <= vec[base+4*l];
            lanes_in[l].scale   <= vec[base+4*l+1];
            lanes_in[l].norm    <= vec[base+4*l+2];
            lanes_in[l].pos     <= vec[base+4*l+3];
        end
    endtask

    initial begin
        int base;
        int waited;
        int chk_fails;
        void'($urandom(32'h8277));
        $readmemh("bench/simil_stage_input.txt", vec);
        RST_i    = 1'b1;
        stall    = 1'b1;
        check    = 1'b0;
        rec      = 0;
        lanes_in = '0;
        bounds   = {vec[6], vec[5], vec[4], vec[3], vec[2], vec[1], vec[0]};
        repeat (10) @(posedge CLK_i);
        RST_i <= 1'b0;

        ////////////////////
        // Records
        ////////////////////
        for (int r = 0; r < NUM_REC; r++) begin
            base = 7 + r * REC_W;
            @(posedge CLK_i);
            load_lanes(base);
            stall <= 1'b1;
            check <= 1'b0;
            for (int s = 0; s < int'(vec[base+8]); s++) begin
                free_step();
            end
            @(posedge CLK_i);
            stall <= 1'b1;
            check <= 1'b1;
            rec   <= r;
        end
        @(posedge CLK_i);
        check <= 1'b0;

        waited = 0;
        while (!finished && waited < DONE_WAIT) begin
            @(posedge CLK_i);
            waited++;
        end
        @(negedge CLK_i);
        chk_fails = simil_stage_top_inst.phase_sequencer_inst.chk_inst.fail_cnt;
        if (!finished) begin
            $display("timeout: finished_o never went high");
        end
        $display("tests %0d, failed tests %0d, errors %0d, assertion failures %0d",
                 NUM_REC, fail_tests, err_cnt, chk_fails);
        if (finished && err_cnt == 0 && chk_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/simil_stage_input.txt
// Line 1: boundaries b0 to b6. Then one record per line:
// l0 operand scale norm pos, l1 operand scale norm pos, steps, l0 op1 op2, l1 op1 op2, phase
0002 0003 0004 0005 0008 000B 000E
4000 3C00 3C00 0000 4200 4000 3C00 0000 0000 4000 3C00 3E00 3C00 0000
4000 3C00 3C00 0000 4200 4000 3C00 0000 0004 4000 3C00 3E00 3C00 0001
4400 3C00 3C00 0000 4880 3C00 3C00 0000 0003 4001 3C00 4202 3C00 0004
3800 3C00 3C00 0003 3400 3C00 3C00 0001 0003 39AA 3C00 3801 3C00 0005
3BE0 3C00 3C00 0007 3A00 3C00 3C00 0005 0001 3BF1 3C00 3AEF 3C00 0005
3A00 3C00 3C00 0009 3800 3C00 3C00 0006 0001 3AEF 3C00 39AA 3C00 0005
3BE0 3C00 3C00 0007 3A00 3C00 3C00 0005 0001 0007 3BE0 1000 3C00 0006
4000 3C00 3C00 0000 4200 4000 3C00 0000 0003 4000 3C00 3E00 3C00 0007
4000 3C00 3C00 0000 4200 4000 3C00 0000 0004 4000 3C00 3E00 3C00 0007

// File: simil_stage_top.f
src/simil_pkg.sv
src/fp16_mul.sv
src/fp16_recip_rom.sv
src/fp16_sqrt_rom.sv
src/norm_lane.sv
src/phase_sequencer.sv
src/simil_stage_top.sv
bench/simil_stage_chk.sv
bench/simil_stage_monitor.sv
bench/simil_stage_tb.sv

// File: Bender.yml
package:
  name: simil_stage

sources:
  - src/simil_pkg.sv
  - src/fp16_mul.sv
  - src/fp16_recip_rom.sv
  - src/fp16_sqrt_rom.sv
  - src/norm_lane.sv
  - src/phase_sequencer.sv
  - src/simil_stage_top.sv
  - target: test
    files:
      - bench/simil_stage_chk.sv
      - bench/simil_stage_monitor.sv
      - bench/simil_stage_tb.sv
